/* evtcnt.f */
hw/evtcnt_pkg.sv
hw/prim_subreg_arb.sv
hw/prim_subreg.sv
hw/evtcnt_reg_top.sv
hw/evtcnt_core.sv
hw/evtcnt_top.sv
tests/evtcnt_tb.sv

/* hw/evtcnt_core.sv */
// ================================================
// Counter core of the event counter.
// Turns event pulses and register state into field
// updates for the register block. The current values
// all come from the registers; only the event is kept.
// ================================================

`timescale 1ns/1ps

module evtcnt_core #(
  parameter int cnt_width = 16
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                event_pulse,
  input  evtcnt_pkg::cfg_t    cfg,
  output evtcnt_pkg::hw2reg_t hw2reg
);

  logic                 evt_q;
  logic [cnt_width-1:0] count_inc;
  logic [cnt_width-1:0] total_inc;
  logic                 count_evt;
  logic                 limit_hit;

  // Registered event. Every update below is driven from this copy, so its
  // effect lands in the fields one edge after the pulse was sampled.
  always_ff @(posedge clk) begin
    if (reset) begin
      evt_q <= 1'b0;
    end else begin
      evt_q <= event_pulse;
    end
  end

  assign count_inc = cfg.count + 1'b1;
  assign total_inc = cfg.evt_total + 1'b1;

  // An enabled event counts unless a clear is pending, which wins.
  assign count_evt = evt_q & cfg.enable & ~cfg.clear_cmd;

  // A zero limit disables the stop, so the count simply runs on.
  assign limit_hit = count_evt && (cfg.limit != '0) && (count_inc == cfg.limit);

  always_comb begin
    hw2reg = '0;

    // The clear command zeroes the count and drops itself on the same edge.
    if (cfg.clear_cmd) begin
      hw2reg.count.d      = '0;
      hw2reg.count.de     = 1'b1;
      hw2reg.cmd_clear.d  = 1'b0;
      hw2reg.cmd_clear.de = 1'b1;
    end else if (count_evt) begin
      hw2reg.count.d  = count_inc;
      hw2reg.count.de = 1'b1;
    end

    // Reaching the limit stops the counter and flags status bit 0.
    if (limit_hit) begin
      hw2reg.ctrl_enable.d    = 1'b0;
      hw2reg.ctrl_enable.de   = 1'b1;
      hw2reg.intr_state.d[0]  = 1'b1;
      hw2reg.intr_state.de[0] = 1'b1;
    end

    // An event while stopped is missed and flags status bit 1.
    if (evt_q && !cfg.enable) begin
      hw2reg.intr_state.d[1]  = 1'b1;
      hw2reg.intr_state.de[1] = 1'b1;
    end

    // The total sees every event and wraps when full.
    if (evt_q) begin
      hw2reg.evt_total.d  = total_inc;
      hw2reg.evt_total.de = 1'b1;
    end
  end

  // The one-shot disable keeps a running count from passing its limit.
  a_count_in_limit: assert property (@(posedge clk) disable iff (reset)
    cfg.enable && (cfg.limit != '0) |-> cfg.count <= cfg.limit);

endmodule

/* hw/evtcnt_pkg.sv */
// ================================================
// Shared definitions for the event-counter block.
// Holds the field access types, the register map and
// the structs that link the bus, the register block
// and the counter core. Import it where it is needed.
// ================================================

package evtcnt_pkg;

  // Software access type of one register field.
  typedef enum logic [2:0] {
    SwAccessRW   = 3'd0,
    SwAccessRO   = 3'd1,
    SwAccessWO   = 3'd2,
    SwAccessW1C  = 3'd3,
    SwAccessW1S  = 3'd4,
    SwAccessW0C  = 3'd5,
    SwAccessRC   = 3'd6,
    SwAccessNone = 3'd7
  } sw_access_e;

  // Width of the counter fields in the structs below.
  // It must match the cnt_width parameter of the top level.
  parameter int cnt_w = 16;

  // Register word addresses.
  parameter int addr_width = 4;
  parameter logic [addr_width-1:0] ctrl_addr        = 4'd0;
  parameter logic [addr_width-1:0] limit_addr       = 4'd1;
  parameter logic [addr_width-1:0] count_addr       = 4'd2;
  parameter logic [addr_width-1:0] intr_state_addr  = 4'd3;
  parameter logic [addr_width-1:0] intr_enable_addr = 4'd4;
  parameter logic [addr_width-1:0] cmd_addr         = 4'd5;
  parameter logic [addr_width-1:0] evt_total_addr   = 4'd6;

  // Bus request, 37 bits.
  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic                  write;
    logic [31:0]           wdata;
  } reg_req_t;

  // Bus response, 33 bits.
  typedef struct packed {
    logic [31:0] rdata;
    logic        error;
  } reg_rsp_t;

  // Register state that steers the core, 50 bits.
  typedef struct packed {
    logic             enable;
    logic [cnt_w-1:0] limit;
    logic [cnt_w-1:0] count;
    logic             clear_cmd;
    logic [cnt_w-1:0] evt_total;
  } cfg_t;

  // Hardware update of one field, a value and its strobe.
  typedef struct packed {
    logic d;
    logic de;
  } hw_bit_t;

  typedef struct packed {
    logic [cnt_w-1:0] d;
    logic             de;
  } hw_cnt_t;

  // The interrupt status carries one strobe per bit.
  typedef struct packed {
    logic [1:0] d;
    logic [1:0] de;
  } hw_intr_t;

  // All hardware updates from the core, 42 bits.
  typedef struct packed {
    hw_bit_t  ctrl_enable;
    hw_cnt_t  count;
    hw_intr_t intr_state;
    hw_bit_t  cmd_clear;
    hw_cnt_t  evt_total;
  } hw2reg_t;

endpackage

/* hw/evtcnt_reg_top.sv */
// ================================================
// Register block of the event counter.
// Accepts one valid/ready bus transaction at a time,
// holds the fields, returns a registered response and
// drives the interrupt from the status and enable.
// ================================================

`timescale 1ns/1ps

module evtcnt_reg_top #(
  parameter int cnt_width = 16
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                req_valid,
  output logic                req_ready,
  input  evtcnt_pkg::reg_req_t req,
  output logic                rsp_valid,
  input  logic                rsp_ready,
  output evtcnt_pkg::reg_rsp_t rsp,
  input  evtcnt_pkg::hw2reg_t hw2reg,
  output evtcnt_pkg::cfg_t    cfg,
  output logic                intr
);
  import evtcnt_pkg::*;

  logic                 xfer;
  logic                 wr_xfer;
  logic                 rd_xfer;
  logic [6:0]           addr_hit;
  logic [31:0]          rdata_next;

  // Stored field values.
  logic                 ctrl_q;
  logic [cnt_width-1:0] limit_q;
  logic [cnt_width-1:0] count_q;
  logic [1:0]           intr_state_q;
  logic [1:0]           intr_enable_q;
  logic                 cmd_q;
  logic [cnt_width-1:0] evt_total_q;

  // Interrupt status update after the per-bit merge.
  logic                 intr_state_de;
  logic [1:0]           intr_state_d;

  // Only one transaction may be in flight, so a new request waits
  // until the previous response has been taken.
  assign req_ready = ~rsp_valid;
  assign xfer      = req_valid & req_ready;
  assign wr_xfer   = xfer & req.write;
  assign rd_xfer   = xfer & ~req.write;

  // Address decode, one hit bit per mapped register.
  always_comb begin
    addr_hit    = '0;
    addr_hit[0] = (req.addr == ctrl_addr);
    addr_hit[1] = (req.addr == limit_addr);
    addr_hit[2] = (req.addr == count_addr);
    addr_hit[3] = (req.addr == intr_state_addr);
    addr_hit[4] = (req.addr == intr_enable_addr);
    addr_hit[5] = (req.addr == cmd_addr);
    addr_hit[6] = (req.addr == evt_total_addr);
  end

  // The core strobes each status bit on its own. Bits without a strobe
  // keep their stored value so the field sees one combined update.
  assign intr_state_de = |hw2reg.intr_state.de;
  assign intr_state_d  = (intr_state_q & ~hw2reg.intr_state.de) |
                         (hw2reg.intr_state.d & hw2reg.intr_state.de);

  prim_subreg #(.DW(1), .SwAccess(SwAccessRW)) u_ctrl (
    .clk (clk), .reset (reset),
    .we  (wr_xfer & addr_hit[0]), .wd (req.wdata[0]),
    .de  (hw2reg.ctrl_enable.de), .d  (hw2reg.ctrl_enable.d),
    .q   (ctrl_q)
  );

  // The limit has no hardware source.
  prim_subreg #(.DW(cnt_width), .SwAccess(SwAccessRW)) u_limit (
    .clk (clk), .reset (reset),
    .we  (wr_xfer & addr_hit[1]), .wd (req.wdata[cnt_width-1:0]),
    .de  (1'b0), .d ('0),
    .q   (limit_q)
  );

  // Software writes reach the count field but are dropped there.
  prim_subreg #(.DW(cnt_width), .SwAccess(SwAccessRO)) u_count (
    .clk (clk), .reset (reset),
    .we  (wr_xfer & addr_hit[2]), .wd (req.wdata[cnt_width-1:0]),
    .de  (hw2reg.count.de), .d  (hw2reg.count.d),
    .q   (count_q)
  );

  prim_subreg #(.DW(2), .SwAccess(SwAccessW1C)) u_intr_state (
    .clk (clk), .reset (reset),
    .we  (wr_xfer & addr_hit[3]), .wd (req.wdata[1:0]),
    .de  (intr_state_de), .d  (intr_state_d),
    .q   (intr_state_q)
  );

  prim_subreg #(.DW(2), .SwAccess(SwAccessRW)) u_intr_enable (
    .clk (clk), .reset (reset),
    .we  (wr_xfer & addr_hit[4]), .wd (req.wdata[1:0]),
    .de  (1'b0), .d ('0),
    .q   (intr_enable_q)
  );

  // Software sets the clear command and the core drops it once done.
  prim_subreg #(.DW(1), .SwAccess(SwAccessW1S)) u_cmd (
    .clk (clk), .reset (reset),
    .we  (wr_xfer & addr_hit[5]), .wd (req.wdata[0]),
    .de  (hw2reg.cmd_clear.de), .d  (hw2reg.cmd_clear.d),
    .q   (cmd_q)
  );

  // The strobe here is the read pulse, so a write has no effect.
  prim_subreg #(.DW(cnt_width), .SwAccess(SwAccessRC)) u_evt_total (
    .clk (clk), .reset (reset),
    .we  (rd_xfer & addr_hit[6]), .wd (req.wdata[cnt_width-1:0]),
    .de  (hw2reg.evt_total.de), .d  (hw2reg.evt_total.d),
    .q   (evt_total_q)
  );

  // Read data is taken from the field values before the transfer edge.
  always_comb begin
    rdata_next = '0;
    case (req.addr)
      ctrl_addr:        rdata_next[0]             = ctrl_q;
      limit_addr:       rdata_next[cnt_width-1:0] = limit_q;
      count_addr:       rdata_next[cnt_width-1:0] = count_q;
      intr_state_addr:  rdata_next[1:0]           = intr_state_q;
      intr_enable_addr: rdata_next[1:0]           = intr_enable_q;
      cmd_addr:         rdata_next[0]             = cmd_q;
      evt_total_addr:   rdata_next[cnt_width-1:0] = evt_total_q;
      default:          rdata_next                = '0;
    endcase
  end

  // The response is valid from the cycle after the transfer until the
  // requester takes it.
  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_valid <= 1'b0;
    end else if (xfer) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  // Response payload. It only loads on a transfer, so it holds while stalled.
  // A write returns zero data and an unmapped address flags an error.
  always_ff @(posedge clk) begin
    if (xfer) begin
      rsp.rdata <= req.write ? '0 : rdata_next;
      rsp.error <= ~|addr_hit;
    end
  end

  // Register state handed to the core.
  assign cfg.enable    = ctrl_q;
  assign cfg.limit     = limit_q;
  assign cfg.count     = count_q;
  assign cfg.clear_cmd = cmd_q;
  assign cfg.evt_total = evt_total_q;

  // Both operands are flop outputs, so intr follows the edge that changes them.
  assign intr = |(intr_state_q & intr_enable_q);

  // A stalled response must keep both its valid and its payload.
  a_rsp_stable: assert property (@(posedge clk) disable iff (reset)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

  // A taken request leaves its response pending, which blocks the next one.
  a_one_outstanding: assert property (@(posedge clk) disable iff (reset)
    xfer |=> rsp_valid && !req_ready);

endmodule

/* hw/evtcnt_top.sv */
// ================================================
// Top level of the event-counter peripheral.
// Joins the register block and the counter core and
// passes the counter width down to both.
// ================================================

`timescale 1ns/1ps

module evtcnt_top #(
  parameter int cnt_width = 16
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req_valid,
  output logic                 req_ready,
  input  evtcnt_pkg::reg_req_t req,
  output logic                 rsp_valid,
  input  logic                 rsp_ready,
  output evtcnt_pkg::reg_rsp_t rsp,
  input  logic                 event_pulse,
  output logic                 intr
);
  import evtcnt_pkg::*;

  // Register state to the core and field updates back.
  cfg_t    cfg;
  hw2reg_t hw2reg;

  evtcnt_reg_top #(
    .cnt_width (cnt_width)
  ) u_reg_top (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp),
    .hw2reg    (hw2reg),
    .cfg       (cfg),
    .intr      (intr)
  );

  evtcnt_core #(
    .cnt_width (cnt_width)
  ) u_core (
    .clk         (clk),
    .reset       (reset),
    .event_pulse (event_pulse),
    .cfg         (cfg),
    .hw2reg      (hw2reg)
  );

endmodule

/* hw/prim_subreg.sv */
// ================================================
// One register field with a synchronous reset value.
// Software and hardware updates pass through the
// write arbitration; q is the stored field value.
// ================================================

`timescale 1ns/1ps

module prim_subreg #(
  parameter int                     DW       = 32,
  parameter evtcnt_pkg::sw_access_e SwAccess = evtcnt_pkg::SwAccessRW,
  parameter logic [DW-1:0]          ResetVal = '0
) (
  input  logic          clk,
  input  logic          reset,
  input  logic          we,
  input  logic [DW-1:0] wd,
  input  logic          de,
  input  logic [DW-1:0] d,
  output logic [DW-1:0] q
);

  logic          wr_en;
  logic [DW-1:0] wr_data;

  prim_subreg_arb #(
    .DW       (DW),
    .SwAccess (SwAccess)
  ) u_arb (
    .we      (we),
    .wd      (wd),
    .de      (de),
    .d       (d),
    .q       (q),
    .wr_en   (wr_en),
    .wr_data (wr_data)
  );

  // The field flop. It holds its value unless the arbiter enables a load.
  always_ff @(posedge clk) begin
    if (reset) begin
      q <= ResetVal;
    end else if (wr_en) begin
      q <= wr_data;
    end
  end

  // Without a strobe from either side the field must keep its value
  // across the next edge.
  a_hold_idle: assert property (@(posedge clk)
    !reset && !we && !de |=> $stable(q));

endmodule

/* hw/prim_subreg_arb.sv */
// ================================================
// Write arbitration for one register field.
// Merges the software strobe and the hardware update
// into a single enable and next value, following the
// access type given by the SwAccess parameter.
// ================================================

`timescale 1ns/1ps

module prim_subreg_arb #(
  parameter int                     DW       = 32,
  parameter evtcnt_pkg::sw_access_e SwAccess = evtcnt_pkg::SwAccessRW
) (
  // Software side. For an RC field the strobe is the read pulse.
  input  logic          we,
  input  logic [DW-1:0] wd,
  // Hardware side.
  input  logic          de,
  input  logic [DW-1:0] d,
  // Present value of the field.
  input  logic [DW-1:0] q,
  // Result that the field flop loads.
  output logic          wr_en,
  output logic [DW-1:0] wr_data
);
  import evtcnt_pkg::*;

  if (SwAccess inside {SwAccessRW, SwAccessWO}) begin : gen_w
    // A software write overrides the hardware value.
    assign wr_en   = we | de;
    assign wr_data = we ? wd : d;
  end else if (SwAccess == SwAccessRO) begin : gen_ro
    // Only hardware can change a read-only field.
    assign wr_en   = de;
    assign wr_data = d;
  end else if (SwAccess == SwAccessW1C) begin : gen_w1c
    // Hardware sets bits and software ones clear them.
    // The clear is applied last, so software wins on a shared bit.
    assign wr_en   = we | de;
    assign wr_data = (de ? d : q) & (we ? ~wd : '1);
  end else if (SwAccess == SwAccessW1S) begin : gen_w1s
    // Hardware clears bits and software ones set them on top.
    assign wr_en   = we | de;
    assign wr_data = (de ? d : q) | (we ? wd : '0);
  end else if (SwAccess == SwAccessW0C) begin : gen_w0c
    // Software zeros clear bits of the base value.
    assign wr_en   = we | de;
    assign wr_data = (de ? d : q) & (we ? wd : '1);
  end else if (SwAccess == SwAccessRC) begin : gen_rc
    // A read empties the field.
    // A hardware update in the same cycle is lost.
    assign wr_en   = we | de;
    assign wr_data = we ? '0 : d;
  end else begin : gen_hw
    // No software access at all.
    assign wr_en   = de;
    assign wr_data = d;
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the event-counter testbench with Verilator and runs it.
# Exits nonzero if the build, the run or the result check fails.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f evtcnt.f --top-module evtcnt_tb -o evtcnt_sim; then
  echo "Verilator build failed"
  exit 1
fi

if ! sim_out=$(./obj_dir/evtcnt_sim); then
  printf '%s\n' "$sim_out"
  echo "Simulation exited with an error"
  exit 1
fi

printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx '=== PASS ==='; then
  exit 0
fi
exit 1

/* tests/evtcnt_tb.sv */
// ================================================
// Directed testbench for the event-counter block.
// Drives the register bus and the event input, keeps
// a model of the register values and checks each
// response against it. Top module is evtcnt_tb.
// ================================================

`timescale 1ns/1ps

module evtcnt_tb;
  import evtcnt_pkg::*;

  // The tests need about a thousand cycles, so this leaves ample margin.
  localparam int max_cycles = 4000;
  localparam int cnt_width = 16;
  localparam logic [31:0] cnt_mask = (32'd1 << cnt_width) - 1;

  logic        clk = 1'b0;
  logic        reset;
  logic        req_valid;
  logic        req_ready;
  reg_req_t    req;
  logic        rsp_valid;
  logic        rsp_ready;
  reg_rsp_t    rsp;
  logic        event_pulse;
  logic        intr;

  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  string       test_name;
  logic [31:0] seed = 32'h8aac_aa97;
  // Expected value of each mapped register, indexed by address.
  logic [31:0] model [0:6];

  evtcnt_top #(.cnt_width(cnt_width)) u_dut (
    .clk         (clk),
    .reset       (reset),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .req         (req),
    .rsp_valid   (rsp_valid),
    .rsp_ready   (rsp_ready),
    .rsp         (rsp),
    .event_pulse (event_pulse),
    .intr        (intr)
  );

  // 20 ns clock period.
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Timeout: the tests did not finish within %0d cycles.", max_cycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // Linear congruential generator for stall lengths, gaps and counts.
  function automatic logic [31:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed >> 16;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Error in %s: %s", test_name, msg);
    end
  endtask

  // One full bus transaction. It returns at the falling edge where the
  // response is valid; with rsp_ready high it completes on the next edge.
  task automatic bus_access(input logic wr, input logic [addr_width-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(posedge clk);
    req_valid  <= 1'b1;
    req.addr   <= addr;
    req.write  <= wr;
    req.wdata  <= wdata;
    do @(negedge clk); while (!req_ready);
    // The transfer takes place on this edge.
    @(posedge clk);
    req_valid <= 1'b0;
    do @(negedge clk); while (!rsp_valid);
    rdata = rsp.rdata;
    err   = rsp.error;
  endtask

  task automatic bus_read(input logic [addr_width-1:0] addr, output logic [31:0] data,
                          output logic err);
    bus_access(1'b0, addr, 32'h0, data, err);
  endtask

  // Write a mapped register and apply the access type to the model.
  task automatic write_reg(input logic [addr_width-1:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    bus_access(1'b1, addr, data, rdata, err);
    check_true(!err, "a write to a mapped register returned an error");
    case (addr)
      ctrl_addr:        model[0] = {31'b0, data[0]};
      limit_addr:       model[1] = data & cnt_mask;
      intr_state_addr:  model[3] = model[3] & ~{30'b0, data[1:0]};
      intr_enable_addr: model[4] = {30'b0, data[1:0]};
      // The clear finishes one edge after the transfer, before any later read.
      cmd_addr:         if (data[0]) model[2] = '0;
      default:          ;
    endcase
  endtask

  // Read a mapped register and compare it with the model.
  task automatic read_check(input logic [addr_width-1:0] addr, input string what);
    logic [31:0] data;
    logic        err;
    bus_read(addr, data, err);
    check_true(!err, "a read of a mapped register returned an error");
    check_value(what, model[addr], data);
    // The event total is read-to-clear.
    if (addr == evt_total_addr) model[6] = '0;
  endtask

  // Apply events to the model by the counting rules.
  task automatic model_events(input int n);
    for (int i = 0; i < n; i++) begin
      model[6] = (model[6] + 1) & cnt_mask;
      if (model[0][0]) begin
        model[2] = (model[2] + 1) & cnt_mask;
        if (model[1] != 0 && model[2] == model[1]) begin
          model[0]    = '0;
          model[3][0] = 1'b1;
        end
      end else begin
        model[3][1] = 1'b1;
      end
    end
  endtask

  // One-cycle pulses with random idle gaps, then quiet time to settle.
  task automatic send_events(input int n);
    int gap;
    for (int i = 0; i < n; i++) begin
      gap = int'(next_random() % 4);
      @(posedge clk);
      event_pulse <= 1'b1;
      @(posedge clk);
      event_pulse <= 1'b0;
      repeat (gap) @(posedge clk);
    end
    repeat (3) @(posedge clk);
    model_events(n);
  endtask

  task automatic test_reset_and_access();
    logic [31:0] data;
    logic        err;
    test_name = "test_reset_and_access";
    @(negedge clk);
    check_true(req_ready && !rsp_valid, "the bus was not idle after reset");
    check_true(!intr, "intr was high after reset");
    for (int a = 0; a < 7; a++) read_check(a[3:0], "reset value");
    write_reg(ctrl_addr, 32'ha5a5_a5a5);
    write_reg(limit_addr, 32'h1234_5678);
    write_reg(intr_enable_addr, 32'hffff_fffe);
    write_reg(count_addr, 32'h0000_0055);
    read_check(ctrl_addr, "ctrl readback");
    read_check(limit_addr, "limit readback");
    read_check(intr_enable_addr, "intr_enable readback");
    read_check(count_addr, "count after write");
    for (int a = 7; a < 16; a++) begin
      bus_read(a[3:0], data, err);
      check_true(err, "an unmapped address returned no error");
      check_value("unmapped rdata", 32'h0, data);
    end
    write_reg(ctrl_addr, 32'h0);
    write_reg(intr_enable_addr, 32'h0);
  endtask

  task automatic test_count_to_limit();
    int limit;
    test_name = "test_count_to_limit";
    limit = 3 + int'(next_random() % 8);
    write_reg(limit_addr, limit);
    write_reg(ctrl_addr, 32'h1);
    send_events(limit);
    read_check(count_addr, "count at limit");
    read_check(ctrl_addr, "ctrl after limit");
    read_check(intr_state_addr, "intr_state after limit");
    check_true(!intr, "intr was high with all interrupts disabled");
    write_reg(intr_enable_addr, 32'h1);
    check_true(intr, "intr stayed low after enabling the limit interrupt");
  endtask

  task automatic test_w1c_and_missed();
    test_name = "test_w1c_and_missed";
    write_reg(intr_enable_addr, 32'h3);
    send_events(1);
    read_check(intr_state_addr, "intr_state after missed event");
    read_check(count_addr, "count after missed event");
    write_reg(intr_state_addr, 32'h1);
    read_check(intr_state_addr, "intr_state after clearing bit 0");
    check_true(intr, "intr fell while the missed status was still set");
    write_reg(intr_state_addr, 32'h2);
    read_check(intr_state_addr, "intr_state after clearing bit 1");
    check_true(!intr, "intr stayed high after all status was cleared");
  endtask

  task automatic test_clear_command();
    test_name = "test_clear_command";
    read_check(count_addr, "count before clear");
    write_reg(cmd_addr, 32'h1);
    read_check(count_addr, "count after clear");
    read_check(cmd_addr, "cmd after clear");
  endtask

  task automatic test_read_clear_total();
    int n;
    test_name = "test_read_clear_total";
    n = 1 + int'(next_random() % 8);
    // A zero limit lets the count run on without a stop.
    write_reg(limit_addr, 32'h0);
    write_reg(ctrl_addr, 32'h1);
    send_events(n);
    read_check(count_addr, "count with zero limit");
    read_check(ctrl_addr, "ctrl with zero limit");
    read_check(evt_total_addr, "evt_total first read");
    read_check(evt_total_addr, "evt_total second read");
    write_reg(ctrl_addr, 32'h0);
  endtask

  task automatic test_backpressure();
    reg_rsp_t held;
    int       stall;
    test_name = "test_backpressure";
    write_reg(limit_addr, 32'h0000_00c3);
    stall = 2 + int'(next_random() % 8);
    @(posedge clk);
    rsp_ready <= 1'b0;
    req_valid <= 1'b1;
    req.addr  <= limit_addr;
    req.write <= 1'b0;
    req.wdata <= 32'h0;
    do @(negedge clk); while (!req_ready);
    // First transfer; the second request is queued right behind it.
    @(posedge clk);
    req.addr <= intr_enable_addr;
    @(negedge clk);
    held = rsp;
    check_value("stalled rdata", model[1], held.rdata);
    repeat (stall) begin
      check_true(rsp_valid && !req_ready, "response dropped or request taken while stalled");
      check_true(rsp == held, "response changed while stalled");
      @(negedge clk);
    end
    @(posedge clk);
    rsp_ready <= 1'b1;
    // The first response completes on this edge.
    @(posedge clk);
    @(negedge clk);
    check_true(req_ready, "req_ready stayed low after the response completed");
    @(posedge clk);
    req_valid <= 1'b0;
    @(negedge clk);
    check_true(rsp_valid, "the queued request got no response");
    check_value("queued rdata", model[4], rsp.rdata);
  endtask

  initial begin
    req_valid   <= 1'b0;
    req         <= '0;
    rsp_ready   <= 1'b1;
    event_pulse <= 1'b0;
    reset       <= 1'b1;
    for (int i = 0; i < 7; i++) model[i] = '0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    test_reset_and_access();
    test_count_to_limit();
    test_w1c_and_missed();
    test_clear_command();
    test_read_clear_total();
    test_backpressure();
    repeat (2) @(posedge clk);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
